// ==== rcc_reset_status.f ====
design/rcc_pkg.sv
design/rcc_axil_port.sv
design/rcc_regs.sv
design/rcc_rsr.sv
design/rcc_reset_status.sv
verif/tb_rcc_reset_status.sv

// ==== verif/rcc_reset_cases.txt ====
// one hex word per line, fields op_addr_data_resp
// op 1 write, 2 read, 3 event with source mask in data, 4 read and 5 write with response held off
2_0_00F80000_0
2_4_00F80000_0
2_8_00000000_0
3_0_00002000_0
2_0_80F80000_0
2_4_80F80000_0
3_0_00000001_0
2_0_80FA0000_0
2_4_80FA0000_0
3_0_00000100_0
2_0_84FA0000_0
1_0_00010000_0
2_0_00010000_0
2_4_84FA0000_0
3_0_00000800_0
2_0_00010000_0
2_4_A4FA0000_0
1_0_00000000_0
2_0_00000000_0
3_0_00000200_0
2_0_08000000_0
2_4_ACFA0000_0
1_8_00000001_0
2_8_00000001_0
1_8_00000000_0
2_8_00000000_0
1_4_FFFEFFFF_0
2_4_ACFA0000_0
1_C_00000001_2
2_C_00000000_2
2_2_00000000_2
4_4_ACFA0000_0
5_8_00000001_0
2_8_00000001_0

// ==== verif/tb_rcc_reset_status.sv ====
// ------------------------------
// case file path relative to project root
// at most 64 cases plus 50 random event rounds
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_reset_status
  import rcc_pkg::*;
();

  logic clk = 1'b0;
  logic rst_n;
  rst_src_t rst_src;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, lsion;
  logic [3:0] awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [1:0] bresp, rresp;

  // op, addr, data, resp per entry
  logic [43:0] cases_mem [0:63];
  int n_cases;
  int errors;
  int checks;
  logic loaded = 1'b0;
  logic [31:0] lcg_state = 32'h01e0_9f85;

  // reference model with index 0 for core 1
  logic [13:0] model_flags [2];
  logic model_rmvf [2];
  logic model_lsion;

  rcc_reset_status UUT (
    .clk(clk), .rst_n(rst_n), .rst_src(rst_src),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .lsion(lsion)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ------------------------------
  // model and checker
  // ------------------------------
  // plain 32-bit lcg step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // flags 13..1 go to bits 31..19 and obl to bit 17
  function automatic logic [31:0] model_word(input int c);
    return {model_flags[c][13:1], 1'b0, model_flags[c][0], model_rmvf[c], 16'h0000};
  endfunction

  // unmapped offsets read zero
  function automatic logic [31:0] model_read(input logic [3:0] addr);
    case (addr)
      4'h0: return model_word(0);
      4'h4: return model_word(1);
      4'h8: return {31'b0, model_lsion};
      default: return 32'h0;
    endcase
  endfunction

  // only rmvf and lsion bits take effect
  task automatic model_write(input logic [3:0] addr, input logic [31:0] data);
    int c;
    c = (addr == 4'h4) ? 1 : 0;
    if (addr == 4'h0 || addr == 4'h4) begin
      model_rmvf[c] = data[16];
      if (data[16]) begin
        model_flags[c] = '0;
      end
    end else if (addr == 4'h8) begin
      model_lsion = data[0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // bus driver
  // ------------------------------
  task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                           input int stall, output logic [1:0] resp);
    logic [1:0] held;
    int i;
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    // wait for the accept cycle
    do begin
      @(negedge clk);
    end while (!(awready && wready));
    @(posedge clk);
    #1;
    // address stays up as a probe while bvalid waits
    awvalid = (stall > 0);
    wvalid  = (stall > 0);
    for (i = 0; i < stall; i++) begin
      @(negedge clk);
      if (i == 0) begin
        held = bresp;
      end
      check_value("bvalid", bvalid, 1'b1);
      check_value("awready", awready, 1'b0);
      check_value("wready", wready, 1'b0);
      check_value("bresp", bresp, held);
      @(posedge clk);
      #1;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    do begin
      @(negedge clk);
    end while (!bvalid);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] addr, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    logic [31:0] held;
    int i;
    @(posedge clk);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    do begin
      @(negedge clk);
    end while (!arready);
    @(posedge clk);
    #1;
    // address stays up as a probe while rvalid waits
    arvalid = (stall > 0);
    for (i = 0; i < stall; i++) begin
      @(negedge clk);
      if (i == 0) begin
        held = rdata;
      end
      check_value("rvalid", rvalid, 1'b1);
      check_value("arready", arready, 1'b0);
      check_value("rdata", rdata, held);
      @(posedge clk);
      #1;
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    do begin
      @(negedge clk);
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // mask high for two edges
  task automatic apply_event(input logic [13:0] mask);
    int c;
    @(posedge clk);
    #1;
    rst_src = mask;
    repeat (2) @(posedge clk);
    #1;
    rst_src = '0;
    for (c = 0; c < 2; c++) begin
      if (!model_rmvf[c]) begin
        model_flags[c] = model_flags[c] | mask;
      end
    end
  endtask

  // rmvf pulse on both cores leaves all flags clear and re-armed
  task automatic clear_both_cores();
    logic [1:0] resp;
    int c;
    for (c = 0; c < 2; c++) begin
      bus_write(c ? 4'h4 : 4'h0, 32'h0001_0000, 0, resp);
      model_write(c ? 4'h4 : 4'h0, 32'h0001_0000);
      bus_write(c ? 4'h4 : 4'h0, 32'h0000_0000, 0, resp);
      model_write(c ? 4'h4 : 4'h0, 32'h0000_0000);
    end
  endtask

  // read back both rsr words against the model
  task automatic compare_both_cores();
    logic [31:0] got;
    logic [1:0] resp;
    bus_read(4'h0, 0, got, resp);
    check_value("rsr c1 rdata", got, model_read(4'h0));
    bus_read(4'h4, 0, got, resp);
    check_value("rsr c2 rdata", got, model_read(4'h4));
  endtask

  task automatic run_case(input logic [43:0] c, input int idx);
    logic [31:0] got;
    logic [1:0] resp;
    case (c[43:40])
      4'd1, 4'd5: begin
        bus_write(c[39:36], c[35:4], (c[43:40] == 4'd5) ? 3 : 0, resp);
        check_value("bresp", resp, c[1:0]);
        model_write(c[39:36], c[35:4]);
      end
      4'd2, 4'd4: begin
        bus_read(c[39:36], (c[43:40] == 4'd4) ? 3 : 0, got, resp);
        check_value("model rdata", model_read(c[39:36]), c[35:4]);
        check_value("rdata", got, c[35:4]);
        check_value("rresp", resp, c[1:0]);
      end
      4'd3: apply_event(c[17:4]);
      default: begin
        errors++;
        $display("case %0d has an unknown operation code", idx);
      end
    endcase
    check_value("lsion", lsion, model_lsion);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int i;
    int k;
    logic [31:0] r;
    logic [1:0] resp;
    rst_n = 1'b0;
    rst_src = '0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    errors = 0;
    checks = 0;
    for (i = 0; i < 64; i++) begin
      cases_mem[i] = '0;
    end
    $readmemh("verif/rcc_reset_cases.txt", cases_mem);
    // first zero op code ends the list
    n_cases = 0;
    while (n_cases < 64 && cases_mem[n_cases][43:40] != 4'd0) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      errors++;
      $display("case file is missing or holds no cases");
    end
    loaded = 1'b1;
    // por, pin, bor, d2, d1 set out of reset
    model_flags[0] = 14'h003E;
    model_flags[1] = 14'h003E;
    model_rmvf[0] = 1'b0;
    model_rmvf[1] = 1'b0;
    model_lsion = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (i = 0; i < n_cases; i++) begin
      run_case(cases_mem[i], i);
    end
    // each source alone on cleared flags of both cores
    for (k = 0; k < 14; k++) begin
      clear_both_cores();
      apply_event(14'd1 << k);
      compare_both_cores();
    end
    // sparse random events with occasional rmvf writes
    for (k = 0; k < 50; k++) begin
      lcg_state = lcg_next(lcg_state);
      r = lcg_state;
      if (r[31:30] == 2'b00) begin
        bus_write(r[29] ? 4'h4 : 4'h0, {15'b0, r[28], 16'h0}, 0, resp);
        model_write(r[29] ? 4'h4 : 4'h0, {15'b0, r[28], 16'h0});
      end
      apply_event(r[13:0] & r[27:14]);
      compare_both_cores();
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // forty clock periods per case and per random round
  initial begin
    wait (loaded);
    #((n_cases + 50) * 40 * 100);
    $display("timeout, the run did not finish in the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/rcc_reset_status.sv ====
// ---------------------------
// reset-cause status unit, two cores, axi4-lite access
// all state on clk, rst_n synchronous
// ---------------------------
`timescale 1ns/1ps
`default_nettype none

module rcc_reset_status
  import rcc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  rst_src_t          rst_src,
  // axi4-lite slave
  input  logic              awvalid,
  output logic              awready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [DATA_W-1:0] wdata,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  // oscillator enable
  output logic              lsion
);

  reg_req_t          req;
  logic [DATA_W-1:0] reg_rdata;
  logic              reg_err;
  rsr_word_u         c1_word;
  rsr_word_u         c2_word;
  logic              c1_rmvf_we;
  logic              c2_rmvf_we;
  logic              rmvf_wdata;

  // bus handshake
  rcc_axil_port u_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rdata_in (reg_rdata),
    .err_in   (reg_err),
    .req      (req)
  );

  // decode, csr and read mux
  rcc_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .c1_word    (c1_word),
    .c2_word    (c2_word),
    .c1_rmvf_we (c1_rmvf_we),
    .c2_rmvf_we (c2_rmvf_we),
    .rmvf_wdata (rmvf_wdata),
    .lsion      (lsion),
    .rdata      (reg_rdata),
    .err        (reg_err)
  );

  // both cores see the same events
  rcc_rsr u_rsr_c1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .rst_src    (rst_src),
    .rmvf_we    (c1_rmvf_we),
    .rmvf_wdata (rmvf_wdata),
    .word       (c1_word)
  );

  rcc_rsr u_rsr_c2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .rst_src    (rst_src),
    .rmvf_we    (c2_rmvf_we),
    .rmvf_wdata (rmvf_wdata),
    .word       (c2_word)
  );

endmodule

`default_nettype wire

// ==== design/rcc_rsr.sv ====
// ---------------------------
// one core's sticky reset flags, all flops on clk
// rmvf high holds every flag at zero
// ---------------------------
`timescale 1ns/1ps
`default_nettype none

module rcc_rsr
  import rcc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // level events, sampled every edge
  input  rst_src_t  rst_src,
  // one-cycle strobe from the register block
  input  logic      rmvf_we,
  input  logic      rmvf_wdata,
  output rsr_word_u word
);

  // flags kept in source order, obl last
  rst_src_t flags_q;
  rst_src_t flags_d;
  logic     rmvf_q;

  // ---------------------------
  // remove-flags bit
  // ---------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rmvf_q <= 1'b0;
    end else if (rmvf_we) begin
      // new value seen from next cycle on
      rmvf_q <= rmvf_wdata;
    end
  end

  // ---------------------------
  // sticky flags
  // ---------------------------
  always_comb begin
    if (rmvf_q) begin
      // clear wins, events dropped
      flags_d = '0;
    end else begin
      // set on any event, hold otherwise
      flags_d = flags_q | rst_src;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // flag bits 31:19 and 17 of the word reset value
      flags_q <= {RSR_RESET_VALUE[31:19], RSR_RESET_VALUE[17]};
    end else begin
      flags_q <= flags_d;
    end
  end

  // ---------------------------
  // status word
  // ---------------------------
  always_comb begin
    // reserved bits stay zero
    word.raw = '0;
    word.f.lpwr2rstf = flags_q.lpwr2;
    word.f.lpwr1rstf = flags_q.lpwr1;
    word.f.wwdg2rstf = flags_q.wwdg2;
    word.f.wwdg1rstf = flags_q.wwdg1;
    word.f.iwdg2rstf = flags_q.iwdg2;
    word.f.iwdg1rstf = flags_q.iwdg1;
    word.f.sft2rstf  = flags_q.sft2;
    word.f.sft1rstf  = flags_q.sft1;
    word.f.porrstf   = flags_q.por;
    word.f.pinrstf   = flags_q.pin;
    word.f.borrstf   = flags_q.bor;
    word.f.d2rstf    = flags_q.d2;
    word.f.d1rstf    = flags_q.d1;
    // bit 18 left reserved
    word.f.oblrstf   = flags_q.obl;
    word.f.rmvf      = rmvf_q;
  end

endmodule

`default_nettype wire

// ==== design/rcc_regs.sv ====
// ---------------------------
// decode and read mux, rdata/err combinational in req cycle
// only rsr bit 16 and csr bit 0 are writable
// ---------------------------
`timescale 1ns/1ps
`default_nettype none

module rcc_regs
  import rcc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  reg_req_t          req,
  // status words from both cores
  input  rsr_word_u         c1_word,
  input  rsr_word_u         c2_word,
  output logic              c1_rmvf_we,
  output logic              c2_rmvf_we,
  output logic              rmvf_wdata,
  output logic              lsion,
  output logic [DATA_W-1:0] rdata,
  output logic              err
);

  logic sel_c1;
  logic sel_c2;
  logic sel_csr;
  logic mapped;

  // ---------------------------
  // offset decode
  // ---------------------------
  assign sel_c1  = (req.addr == RSR_C1_ADDR);
  assign sel_c2  = (req.addr == RSR_C2_ADDR);
  assign sel_csr = (req.addr == CSR_ADDR);
  assign mapped  = sel_c1 | sel_c2 | sel_csr;

  // rmvf strobes, one per core
  assign c1_rmvf_we = req.wr & sel_c1;
  assign c2_rmvf_we = req.wr & sel_c2;
  // other rsr bits of the write are dropped
  assign rmvf_wdata = req.wdata[RMVF_BIT];

  // ---------------------------
  // csr, oscillator enable
  // ---------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lsion <= 1'b0;
    end else if (req.wr && sel_csr) begin
      lsion <= req.wdata[LSION_BIT];
    end
  end

  // ---------------------------
  // read mux
  // ---------------------------
  always_comb begin
    rdata = '0;
    if (sel_c1) begin
      rdata = c1_word.raw;
    end else if (sel_c2) begin
      rdata = c2_word.raw;
    end else if (sel_csr) begin
      // ready bit not implemented, reads zero
      rdata[LSION_BIT] = lsion;
    end
  end

  // unmapped offsets answer slverr on either access
  assign err = (req.wr | req.rd) & ~mapped;

endmodule

`default_nettype wire

// ==== design/rcc_axil_port.sv ====
// ---------------------------
// axi4-lite slave, one transfer outstanding, no prot/strb
// write wins over read in the same cycle
// ---------------------------
`timescale 1ns/1ps
`default_nettype none

module rcc_axil_port
  import rcc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // write address / data
  input  logic              awvalid,
  output logic              awready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [DATA_W-1:0] wdata,
  // write response
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  // read address
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] araddr,
  // read data
  output logic              rvalid,
  input  logic              rready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  // register block side
  input  logic [DATA_W-1:0] rdata_in,
  input  logic              err_in,
  output reg_req_t          req
);

  // pending-response state, both low means idle
  logic wr_pend;
  logic rd_pend;
  logic idle;
  logic wr_go;
  logic rd_go;

  // ---------------------------
  // acceptance
  // ---------------------------
  assign idle  = ~wr_pend & ~rd_pend;
  // write needs both aw and w in the same cycle
  assign wr_go = idle & awvalid & wvalid;
  assign rd_go = idle & arvalid & ~wr_go;

  // ready pulses only in the accept cycle
  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // request lives for the accept cycle only
  always_comb begin
    req.wr    = wr_go;
    req.rd    = rd_go;
    req.addr  = wr_go ? awaddr : araddr;
    req.wdata = wdata;
  end

  // ---------------------------
  // response state
  // ---------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_pend <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      if (wr_go) begin
        wr_pend <= 1'b1;
      end else if (wr_pend && bready) begin
        wr_pend <= 1'b0;
      end
      if (rd_go) begin
        rd_pend <= 1'b1;
      end else if (rd_pend && rready) begin
        rd_pend <= 1'b0;
      end
    end
  end

  // response payload, captured at accept and held while pending
  always_ff @(posedge clk) begin
    if (wr_go) begin
      bresp <= err_in ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_go) begin
      rdata <= rdata_in;
      rresp <= err_in ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign bvalid = wr_pend;
  assign rvalid = rd_pend;

endmodule

`default_nettype wire

// ==== design/rcc_pkg.sv ====
// ---------------------------
// fixed register map, no parameters on modules
// rsr layout and reset value shared by both cores
// ---------------------------
`default_nettype none

package rcc_pkg;

  // ---------------------------
  // bus geometry and map
  // ---------------------------
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  // word offsets, anything else is unmapped
  localparam logic [ADDR_W-1:0] RSR_C1_ADDR = 4'h0;
  localparam logic [ADDR_W-1:0] RSR_C2_ADDR = 4'h4;
  localparam logic [ADDR_W-1:0] CSR_ADDR    = 4'h8;

  // writable bit positions
  localparam int RMVF_BIT  = 16;
  localparam int LSION_BIT = 0;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // por, pin, bor, d2, d1 flags set out of reset
  localparam logic [DATA_W-1:0] RSR_RESET_VALUE = 32'h00F8_0000;

  // ---------------------------
  // types
  // ---------------------------
  // reset source events, msb first in status-word order
  typedef struct packed {
    logic lpwr2;
    logic lpwr1;
    logic wwdg2;
    logic wwdg1;
    logic iwdg2;
    logic iwdg1;
    logic sft2;
    logic sft1;
    logic por;
    logic pin;
    logic bor;
    logic d2;
    logic d1;
    logic obl;
  } rst_src_t;

  // rsr word as fields
  typedef struct packed {
    logic        lpwr2rstf;
    logic        lpwr1rstf;
    logic        wwdg2rstf;
    logic        wwdg1rstf;
    logic        iwdg2rstf;
    logic        iwdg1rstf;
    logic        sft2rstf;
    logic        sft1rstf;
    logic        porrstf;
    logic        pinrstf;
    logic        borrstf;
    logic        d2rstf;
    logic        d1rstf;
    // reads zero
    logic        rsvd18;
    logic        oblrstf;
    logic        rmvf;
    logic [15:0] rsvd_lo;
  } rsr_fields_t;

  // same word, field view or raw bus view
  typedef union packed {
    rsr_fields_t             f;
    logic [DATA_W-1:0] raw;
  } rsr_word_u;

  // one register access, port to register block
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

endpackage

`default_nettype wire
